// File: design/line_consts.svh
`ifndef LINE_CONSTS_SVH
`define LINE_CONSTS_SVH

// screen coordinate width, one axis
`define COORD_W 6

// bits per pixel
`define COLOR_W 4

// frame is square, FB_DIM cells per side
`define FB_DIM 64

// total cells, also the number of cycles a clear sweep takes
`define FB_WORDS 4096

`endif

// File: design/line_pkg.sv
`default_nettype none

`include "line_consts.svh"

package line_pkg;

  // one axis of a screen position
  typedef logic [`COORD_W-1:0] coord_t;

  // pixel colour
  typedef logic [`COLOR_W-1:0] color_t;

  // span length, 1 up to a full row or column
  // needs one bit more than a coordinate to hold FB_DIM itself
  typedef logic [`COORD_W:0] len_t;

  // bresenham error term, signed with headroom for err - d_min + d_maj
  typedef logic signed [`COORD_W+1:0] err_t;

endpackage

`default_nettype wire

// File: design/line_setup.sv
`default_nettype none

module line_setup (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   plot,         // host request strobe
  input  wire line_pkg::coord_t x0,
  input  wire line_pkg::coord_t y0,
  input  wire line_pkg::coord_t x1,
  input  wire line_pkg::coord_t y1,
  input  wire line_pkg::color_t color,
  output logic                  busy,
  input  wire                   stepper_busy, // back-pressure from stage 2
  output logic                  line_go,
  output line_pkg::coord_t      maj0,         // start of walk, major axis
  output line_pkg::coord_t      maj1,         // end of walk, major axis
  output line_pkg::coord_t      min0,         // start, minor axis
  output line_pkg::coord_t      d_maj,
  output line_pkg::coord_t      d_min,
  output logic                  min_up,       // minor coordinate counts up
  output logic                  steep,        // axes were swapped
  output line_pkg::color_t      line_color
);

  import line_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SWAP,   // make x the major axis
    S_ORDER,  // make the walk run upward
    S_READY   // hold result until stepper is free
  } state_t;

  state_t state;
  coord_t min1; // minor end point, only needed for the direction

  assign busy    = (state != S_IDLE);
  assign line_go = (state == S_READY) && !stepper_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (plot) state <= S_SWAP;
        S_SWAP:  state <= S_ORDER;
        S_ORDER: state <= S_READY;
        S_READY: if (!stepper_busy) state <= S_IDLE; // handed over on line_go
        default: state <= S_IDLE;
      endcase
    end
  end

  // working registers double as the outputs to stage 2
  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: if (plot) begin
        maj0       <= x0;
        min0       <= y0;
        maj1       <= x1;
        min1       <= y1;
        d_maj      <= (x1 > x0) ? x1 - x0 : x0 - x1; // |dx|
        d_min      <= (y1 > y0) ? y1 - y0 : y0 - y1; // |dy|
        line_color <= color;
      end
      S_SWAP: begin
        steep <= d_min > d_maj; // tie stays shallow
        if (d_min > d_maj) begin
          maj0  <= min0;
          min0  <= maj0;
          maj1  <= min1;
          min1  <= maj1;
          d_maj <= d_min;
          d_min <= d_maj;
        end
      end
      S_ORDER: begin
        if (maj0 > maj1) begin // walk from the lower major end
          maj0   <= maj1;
          maj1   <= maj0;
          min0   <= min1;
          min1   <= min0;
          min_up <= min0 > min1; // direction seen from the new start
        end else begin
          min_up <= min1 > min0;
        end
      end
      default: ; // S_READY holds everything
    endcase
  end

endmodule

`default_nettype wire

// File: design/line_stepper.sv
`default_nettype none

module line_stepper (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   line_go,      // one-cycle load from setup
  input  wire line_pkg::coord_t maj0,
  input  wire line_pkg::coord_t maj1,
  input  wire line_pkg::coord_t min0,
  input  wire line_pkg::coord_t d_maj,
  input  wire line_pkg::coord_t d_min,
  input  wire                   min_up,
  input  wire                   steep,
  input  wire line_pkg::color_t line_color,
  output logic                  stepper_busy,
  input  wire                   span_busy,    // writer still expanding a span
  output logic                  span_plot,
  output line_pkg::coord_t      span_x,
  output line_pkg::coord_t      span_y,
  output line_pkg::len_t        span_len,
  output logic                  span_vertical,
  output line_pkg::color_t      span_color
);

  import line_pkg::*;

  coord_t maj_cur;   // walk position, major axis
  coord_t maj_end;
  coord_t min_cur;   // minor position, also the minor coord of the open run
  coord_t run_maj;   // where the open run started on the major axis
  len_t   run_len;   // pixels in the open run
  err_t   err;
  err_t   e_dmaj;    // deltas widened to the error width
  err_t   e_dmin;
  coord_t dmaj_r;
  coord_t dmin_r;
  logic   up_r;
  logic   steep_r;
  color_t color_r;

  logic walk;     // allowed to take a step this cycle
  logic at_end;
  logic step_min; // minor coordinate moves on this step
  logic emit;     // close the open run and hand it to the writer

  assign e_dmaj = err_t'({2'b00, dmaj_r});
  assign e_dmin = err_t'({2'b00, dmin_r});

  // span_plot still high means the writer has not taken it yet
  assign walk     = stepper_busy && !span_busy && !span_plot;
  assign at_end   = (maj_cur == maj_end);
  assign step_min = (err < e_dmin);
  assign emit     = walk && (at_end || step_min);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stepper_busy <= 1'b0;
      span_plot    <= 1'b0;
    end else begin
      span_plot <= emit; // single-cycle strobe
      if (line_go) begin
        stepper_busy <= 1'b1;
      end else if (walk && at_end) begin
        stepper_busy <= 1'b0; // last span goes out this edge
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_go) begin
      maj_cur <= maj0;
      maj_end <= maj1;
      min_cur <= min0;
      run_maj <= maj0;
      run_len <= len_t'(1);
      err     <= err_t'({2'b00, d_maj >> 1}); // half the major delta, floor
      dmaj_r  <= d_maj;
      dmin_r  <= d_min;
      up_r    <= min_up;
      steep_r <= steep;
      color_r <= line_color;
    end else if (walk) begin
      if (emit) begin
        // back to screen order: steep lines walked along y
        span_x        <= steep_r ? min_cur : run_maj;
        span_y        <= steep_r ? run_maj : min_cur;
        span_len      <= run_len;
        span_vertical <= steep_r;
        span_color    <= color_r;
      end
      if (!at_end) begin
        maj_cur <= maj_cur + coord_t'(1);
        if (step_min) begin // staircase step, new run starts here
          min_cur <= up_r ? min_cur + coord_t'(1) : min_cur - coord_t'(1);
          err     <= err - e_dmin + e_dmaj;
          run_maj <= maj_cur + coord_t'(1);
          run_len <= len_t'(1);
        end else begin // straight step, run grows
          err     <= err - e_dmin;
          run_len <= run_len + len_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/span_writer.sv
`default_nettype none

module span_writer (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   span_plot,
  input  wire line_pkg::coord_t span_x,
  input  wire line_pkg::coord_t span_y,
  input  wire line_pkg::len_t   span_len,
  input  wire                   span_vertical, // run along y instead of x
  input  wire line_pkg::color_t span_color,
  output logic                  span_busy,
  output logic                  pix_we,
  output line_pkg::coord_t      pix_x,
  output line_pkg::coord_t      pix_y,
  output line_pkg::color_t      pix_color
);

  import line_pkg::*;

  coord_t cur_x;
  coord_t cur_y;
  len_t   left;    // pixels still to write, including the current one
  logic   vert_r;
  color_t color_r;

  // one pixel per busy cycle straight from the working registers
  assign pix_we    = span_busy;
  assign pix_x     = cur_x;
  assign pix_y     = cur_y;
  assign pix_color = color_r;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      span_busy <= 1'b0;
    end else if (span_plot) begin
      span_busy <= 1'b1;
    end else if (span_busy && left == len_t'(1)) begin
      span_busy <= 1'b0; // last pixel written this cycle
    end
  end

  always_ff @(posedge clk) begin
    if (span_plot) begin
      cur_x   <= span_x;
      cur_y   <= span_y;
      left    <= span_len;
      vert_r  <= span_vertical;
      color_r <= span_color;
    end else if (span_busy) begin
      left <= left - len_t'(1);
      if (vert_r) begin
        cur_y <= cur_y + coord_t'(1);
      end else begin
        cur_x <= cur_x + coord_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/frame_buffer.sv
`default_nettype none

`include "line_consts.svh"

module frame_buffer (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   pix_we,
  input  wire line_pkg::coord_t pix_x,
  input  wire line_pkg::coord_t pix_y,
  input  wire line_pkg::color_t pix_color,
  input  wire                   clear,     // one-cycle strobe, starts the sweep
  output logic                  clearing,
  input  wire line_pkg::coord_t rd_x,
  input  wire line_pkg::coord_t rd_y,
  output line_pkg::color_t      rd_color   // one cycle after rd_x/rd_y
);

  import line_pkg::*;

  color_t mem [`FB_DIM][`FB_DIM]; // [y][x]

  logic [2*`COORD_W-1:0] clr_addr; // {y, x} of the cell being wiped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clearing <= 1'b0;
      clr_addr <= '0;
    end else if (clear) begin
      clearing <= 1'b1; // a second clear restarts the sweep
      clr_addr <= '0;
    end else if (clearing) begin
      clr_addr <= clr_addr + 1'b1;
      if (clr_addr == (2*`COORD_W)'(`FB_WORDS - 1)) clearing <= 1'b0;
    end
  end

  // sweep owns the write port while it runs
  always_ff @(posedge clk) begin
    if (clearing) begin
      mem[clr_addr[2*`COORD_W-1:`COORD_W]][clr_addr[`COORD_W-1:0]] <= '0;
    end else if (pix_we) begin
      mem[pix_y][pix_x] <= pix_color;
    end
    rd_color <= mem[rd_y][rd_x];
  end

endmodule

`default_nettype wire

// File: design/line_engine_top.sv
`default_nettype none

module line_engine_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   plot,
  input  wire line_pkg::coord_t x0,
  input  wire line_pkg::coord_t y0,
  input  wire line_pkg::coord_t x1,
  input  wire line_pkg::coord_t y1,
  input  wire line_pkg::color_t color,
  output logic                  busy,
  output logic                  idle,   // nothing in flight, no clear running
  input  wire                   clear,
  input  wire line_pkg::coord_t rd_x,
  input  wire line_pkg::coord_t rd_y,
  output line_pkg::color_t      rd_color
);

  import line_pkg::*;

  // setup -> stepper
  logic   line_go;
  coord_t maj0;
  coord_t maj1;
  coord_t min0;
  coord_t d_maj;
  coord_t d_min;
  logic   min_up;
  logic   steep;
  color_t line_color;
  logic   stepper_busy;

  // stepper -> span writer
  logic   span_plot;
  coord_t span_x;
  coord_t span_y;
  len_t   span_len;
  logic   span_vertical;
  color_t span_color;
  logic   span_busy;

  // span writer -> frame buffer
  logic   pix_we;
  coord_t pix_x;
  coord_t pix_y;
  color_t pix_color;
  logic   clearing;

  // span_plot covers the cycle between stepper and writer being busy
  assign idle = !busy && !stepper_busy && !span_plot && !span_busy && !clearing;

  line_setup u_setup (
    .clk, .rst_n, .plot, .x0, .y0, .x1, .y1, .color, .busy, .stepper_busy,
    .line_go, .maj0, .maj1, .min0, .d_maj, .d_min, .min_up, .steep, .line_color
  );

  line_stepper u_stepper (
    .clk, .rst_n, .line_go, .maj0, .maj1, .min0, .d_maj, .d_min, .min_up, .steep,
    .line_color, .stepper_busy, .span_busy, .span_plot, .span_x, .span_y,
    .span_len, .span_vertical, .span_color
  );

  span_writer u_writer (
    .clk, .rst_n, .span_plot, .span_x, .span_y, .span_len, .span_vertical,
    .span_color, .span_busy, .pix_we, .pix_x, .pix_y, .pix_color
  );

  frame_buffer u_fb (
    .clk, .rst_n, .pix_we, .pix_x, .pix_y, .pix_color, .clear, .clearing,
    .rd_x, .rd_y, .rd_color
  );

endmodule

`default_nettype wire

// File: dv/line_engine_assert.sv
`default_nettype none

module line_engine_assert (
  input wire                 clk,
  input wire                 rst_n,
  input wire                 plot,
  input wire                 clear,
  input wire                 span_plot,
  input wire                 span_busy,
  input wire line_pkg::len_t span_len,
  input wire                 pix_we,
  input wire                 clearing,
  input wire                 idle
);

  // stepper must wait for the writer to drain before the next span
  plot_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    span_plot |-> !span_busy)
    else $error("span_plot raised while the span writer is busy");

  zero_length_span: assert property (@(posedge clk) disable iff (!rst_n)
    span_plot |-> (span_len != '0))
    else $error("span handed on with length zero");

  // pixel writes would be dropped while the sweep owns the memory
  write_during_clear: assert property (@(posedge clk) disable iff (!rst_n)
    clearing |-> !pix_we)
    else $error("pixel write while the frame buffer is clearing");

  // no work may still be hidden in a stage once idle is reported
  idle_without_request: assert property (@(posedge clk) disable iff (!rst_n)
    idle && !plot && !clear |=> idle)
    else $error("engine left idle without a plot or clear request");

endmodule

`default_nettype wire

// File: dv/line_engine_tb.sv
`default_nettype none

`include "line_consts.svh"

module line_engine_tb;

  import line_pkg::*;

  localparam int N_LINES  = 16 + 8 + 40 + 12; // octants, degenerate, burst, after clear
  localparam int N_SWEEPS = 8;                // 2 clears + 6 full readbacks
  localparam int WATCHDOG_CYCLES = N_LINES * 200 + N_SWEEPS * (`FB_WORDS + 16) + 16;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   plot;
  coord_t x0, y0, x1, y1;
  color_t color;
  logic   busy;
  logic   idle;
  logic   clear;
  coord_t rd_x, rd_y;
  color_t rd_color;

  logic [15:0] lfsr = 16'd11;           // stimulus seed
  color_t model [`FB_DIM][`FB_DIM];     // expected frame indexed [y][x]

  // one delta pair per octant going round the circle
  int oct_dx [8] = '{13, 5, -5, -13, -13, -5, 5, 13};
  int oct_dy [8] = '{5, 13, 13, 5, -5, -13, -13, -5};

  always #2 clk = ~clk;

  line_engine_top dut0 (
    .clk, .rst_n, .plot, .x0, .y0, .x1, .y1, .color, .busy, .idle,
    .clear, .rd_x, .rd_y, .rd_color
  );

  bind line_engine_top line_engine_assert u_assert (
    .clk, .rst_n, .plot, .clear, .span_plot, .span_busy, .span_len, .pix_we,
    .clearing, .idle
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // plain bresenham pixel loop over the model
  task automatic draw_model(input int ax, input int ay, input int bx, input int by, input int c);
    int dx, dy;
    int mj, mn, mn_end;
    int dmaj, dmin, err, dir;
    dx = (bx > ax) ? bx - ax : ax - bx;
    dy = (by > ay) ? by - ay : ay - by;
    if (dy > dx) begin // walk along y
      mj     = (ay <= by) ? ay : by;
      mn     = (ay <= by) ? ax : bx;
      mn_end = (ay <= by) ? bx : ax;
      dmaj   = dy;
      dmin   = dx;
    end else begin     // ties also walk along x
      mj     = (ax <= bx) ? ax : bx;
      mn     = (ax <= bx) ? ay : by;
      mn_end = (ax <= bx) ? by : ay;
      dmaj   = dx;
      dmin   = dy;
    end
    dir = (mn_end > mn) ? 1 : -1;
    err = dmaj / 2;
    for (int i = 0; i <= dmaj; i++) begin
      if (dy > dx) model[mj][mn] = color_t'(c);
      else model[mn][mj] = color_t'(c);
      if (err < dmin) begin
        mn  = mn + dir;
        err = err - dmin + dmaj;
      end else begin
        err = err - dmin;
      end
      mj++;
    end
  endtask

  // one-cycle plot strobe once setup is free
  task automatic plot_line(input int ax, input int ay, input int bx, input int by, input int c);
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    plot  <= 1'b1;
    x0    <= coord_t'(ax);
    y0    <= coord_t'(ay);
    x1    <= coord_t'(bx);
    y1    <= coord_t'(by);
    color <= color_t'(c);
    @(posedge clk);
    plot  <= 1'b0;
    draw_model(ax, ay, bx, by, c); // model follows request order
  endtask

  task automatic plot_random(input int n);
    int ax, ay, bx, by, c;
    for (int i = 0; i < n; i++) begin
      ax = take_bits(6);
      ay = take_bits(6);
      bx = take_bits(6);
      by = take_bits(6);
      c  = take_bits(4);
      plot_line(ax, ay, bx, by, c);
    end
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!idle) @(negedge clk);
  endtask

  task automatic clear_frame();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    for (int y = 0; y < `FB_DIM; y++) begin
      for (int x = 0; x < `FB_DIM; x++) model[y][x] = '0;
    end
  endtask

  // data for address i-1 shows up while address i is driven
  task automatic check_frame(input string tag);
    int x, y;
    for (int i = 0; i <= `FB_WORDS; i++) begin
      @(posedge clk);
      if (i < `FB_WORDS) begin
        rd_x <= coord_t'(i % `FB_DIM);
        rd_y <= coord_t'(i / `FB_DIM);
      end
      @(negedge clk);
      if (i > 0) begin
        x = (i - 1) % `FB_DIM;
        y = (i - 1) / `FB_DIM;
        check_eq(rd_color, model[y][x], $sformatf("%s x=%0d y=%0d", tag, x, y));
      end
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: engine did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    rst_n = 1'b0;
    plot  = 1'b0;
    x0    = '0;
    y0    = '0;
    x1    = '0;
    y1    = '0;
    color = '0;
    clear = 1'b0;
    rd_x  = '0;
    rd_y  = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq(busy, 1'b0, "busy after reset");
    check_eq(idle, 1'b1, "idle after reset");

    clear_frame();
    wait_idle();
    check_frame("clear");

    for (int i = 0; i < 8; i++) begin
      plot_line(16, 16, 16 + oct_dx[i], 16 + oct_dy[i], i + 1); // outward
      plot_line(47 + oct_dx[i], 47 + oct_dy[i], 47, 47, i + 8);  // inward
    end
    wait_idle();
    check_frame("octants");

    plot_line(10, 20, 10, 20, 3);  // single point
    plot_line(3, 40, 60, 40, 4);
    plot_line(50, 5, 2, 5, 5);
    plot_line(0, 63, 63, 63, 6);   // full row as one span of 64
    plot_line(30, 1, 30, 62, 7);
    plot_line(7, 55, 7, 0, 9);
    plot_line(0, 0, 63, 63, 10);   // diagonals with all spans of length 1
    plot_line(63, 0, 0, 63, 11);
    wait_idle();
    check_frame("degenerate");

    plot_random(40); // back to back so the stages fill up
    wait_idle();
    check_frame("burst");

    clear_frame();
    wait_idle();
    check_frame("clear after burst");

    plot_random(12);
    wait_idle();
    check_frame("after clear");

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/line_pkg.sv
design/line_setup.sv
design/line_stepper.sv
design/span_writer.sv
design/frame_buffer.sv
design/line_engine_top.sv
dv/line_engine_assert.sv
dv/line_engine_tb.sv

// File: run.sh
#!/bin/sh
# build and run the line engine testbench with verilator
set -e
verilator --binary --assert -Wno-fatal --top-module line_engine_tb -f list.f \
  -o sim_line_engine
output=$(./obj_dir/sim_line_engine 2>&1 || true)
echo "$output"
if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi
